// ==== verilog/rv32i_types.sv ====
package rv32i_types;

    localparam int DMEM_WORDS = 256;    // words per bank
    localparam int DMEM_AW    = 8;      // word index is addr[9:2]

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } funct3_t;

    // store codes alias the load codes, as in RV32I
    localparam funct3_t sb = lb;
    localparam funct3_t sh = lh;
    localparam funct3_t sw = lw;

    typedef struct packed {
        logic [63:0] order;
        logic [31:0] mem_addr;
        logic [3:0]  mem_rmask;
        logic [3:0]  mem_wmask;
        logic [31:0] mem_wdata;
        logic [31:0] mem_rdata;
    } mem_mon_t;

    typedef struct packed {
        logic        valid;
        logic        mem_read;
        logic        mem_write;
        funct3_t     funct3;
        logic [31:0] alu_result;
        logic [31:0] rs2_v;
        logic [4:0]  rd_s;
        logic        regf_we;
        mem_mon_t    mon;           // only order is filled upstream
    } ex_mem_reg_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd_s;
        logic        regf_we;
        logic        mem_read;
        logic [31:0] rd_v;
        logic [31:0] read_data;
        mem_mon_t    mon;
    } mem_wb_reg_t;

    typedef struct packed {
        logic               req;
        logic [DMEM_AW-1:0] addr;
        logic [3:0]         rmask;
        logic [3:0]         wmask;
        logic [31:0]        wdata;
    } dmem_req_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd_s;
        logic        we;
        logic [31:0] rd_wdata;
        mem_mon_t    mon;
    } retire_t;

endpackage

// ==== verilog/dmem_bank.sv ====
`timescale 1ns/100ps

module dmem_bank (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            we,
    input  logic [rv32i_types::DMEM_AW-1:0] addr,
    input  logic [7:0]                      wdata,
    output logic [7:0]                      rdata
);
    import rv32i_types::*;

    logic [7:0] mem [DMEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];     // old contents come back on a write
        end
    end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  rv32i_types::ex_mem_reg_t ex_mem_in,
    input  logic [31:0]              dmem_rdata,
    input  logic                     dmem_resp,
    output rv32i_types::dmem_req_t   dmem_req,
    output logic                     dstall,
    output rv32i_types::mem_wb_reg_t mem_wb_next
);
    import rv32i_types::*;

    logic        pend;          // a memory op is waiting for its response
    logic        start;
    ex_mem_reg_t held;
    ex_mem_reg_t cur;
    logic        is_mem;
    logic [1:0]  off;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [31:0] lane_wdata;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic [31:0] load_data;

    assign start  = ex_mem_in.valid & ~pend & (ex_mem_in.mem_read | ex_mem_in.mem_write);
    assign cur    = pend ? held : ex_mem_in;
    assign is_mem = cur.mem_read | cur.mem_write;
    assign off    = cur.alu_result[1:0];

    // masks and lane placement
    always_comb
    begin
        rmask      = '0;
        wmask      = '0;
        lane_wdata = '0;
        if (cur.mem_read)
        begin
            case (cur.funct3)
                lb, lbu: rmask = 4'b0001 << off;
                lh, lhu: rmask = 4'b0011 << off;
                lw:      rmask = 4'b1111;
                default: rmask = '0;
            endcase
        end
        if (cur.mem_write)
        begin
            case (cur.funct3)
                sb:
                begin
                    wmask = 4'b0001 << off;
                    lane_wdata[8*off +: 8] = cur.rs2_v[7:0];
                end
                sh:
                begin
                    wmask = 4'b0011 << off;
                    lane_wdata[16*off[1] +: 16] = cur.rs2_v[15:0];
                end
                sw:
                begin
                    wmask      = 4'b1111;
                    lane_wdata = cur.rs2_v;
                end
                default:
                begin
                    wmask      = '0;
                    lane_wdata = '0;
                end
            endcase
        end
    end

    always_comb
    begin
        dmem_req.req   = start;
        dmem_req.addr  = cur.alu_result[DMEM_AW+1:2];
        dmem_req.rmask = rmask;
        dmem_req.wmask = wmask;
        dmem_req.wdata = lane_wdata;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pend <= 1'b0;
        else if (start)
            pend <= 1'b1;
        else if (dmem_resp)
            pend <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (start)
            held <= ex_mem_in;
    end

    assign dstall = pend;

    assign load_byte = dmem_rdata[8*off +: 8];
    assign load_half = dmem_rdata[16*off[1] +: 16];

    always_comb
    begin
        case (cur.funct3)
            lb:      load_data = {{24{load_byte[7]}}, load_byte};
            lbu:     load_data = {24'b0, load_byte};
            lh:      load_data = {{16{load_half[15]}}, load_half};
            lhu:     load_data = {16'b0, load_half};
            default: load_data = dmem_rdata;
        endcase
    end

    always_comb
    begin
        mem_wb_next.valid     = pend ? dmem_resp : (ex_mem_in.valid & ~is_mem);
        mem_wb_next.rd_s      = cur.rd_s;
        mem_wb_next.regf_we   = cur.regf_we;
        mem_wb_next.mem_read  = cur.mem_read;
        mem_wb_next.rd_v      = cur.alu_result;
        mem_wb_next.read_data = load_data;

        mem_wb_next.mon.order     = cur.mon.order;
        mem_wb_next.mon.mem_addr  = is_mem ? {cur.alu_result[31:2], 2'b00} : '0;
        mem_wb_next.mon.mem_rmask = rmask;
        mem_wb_next.mon.mem_wmask = wmask;
        mem_wb_next.mon.mem_wdata = lane_wdata;
        mem_wb_next.mon.mem_rdata = pend ? dmem_rdata : '0;   // raw bank word
    end

    // upstream has to honour the stall
    a_no_strobe_in_stall: assert property (
        @(posedge clk) disable iff (rst) dstall |-> !ex_mem_in.valid
    ) else $error("mem_stage: input strobe while dstall is high");

    // memory must only answer an outstanding request
    a_resp_needs_hold: assert property (
        @(posedge clk) disable iff (rst) dmem_resp |-> pend
    ) else $error("mem_stage: dmem_resp without a pending request");

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/100ps

module data_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  rv32i_types::dmem_req_t dmem_req,
    output logic [31:0]            dmem_rdata,
    output logic                   dmem_resp
);

    logic [3:0] lane_en;
    logic [3:0] lane_we;

    assign lane_en = {4{dmem_req.req}};         // every lane reads on a request
    assign lane_we = lane_en & dmem_req.wmask;

    generate
        for (genvar i = 0; i < 4; i++)
        begin : g_lane
            dmem_bank u_bank (
                .clk   (clk),
                .en    (lane_en[i]),
                .we    (lane_we[i]),
                .addr  (dmem_req.addr),
                .wdata (dmem_req.wdata[8*i +: 8]),
                .rdata (dmem_rdata[8*i +: 8])
            );
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        if (rst)
            dmem_resp <= 1'b0;
        else
            dmem_resp <= dmem_req.req;
    end

    // a request is either a load or a store, never both
    a_not_rw: assert property (
        @(posedge clk) disable iff (rst)
        dmem_req.req |-> !((|dmem_req.rmask) && (|dmem_req.wmask))
    ) else $error("data_mem: read and write masks both set");

endmodule

// ==== verilog/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  rv32i_types::mem_wb_reg_t mem_wb_next,
    output rv32i_types::retire_t     retire
);
    import rv32i_types::*;

    mem_wb_reg_t mem_wb_reg;

    always_ff @(posedge clk)
    begin
        if (mem_wb_next.valid)
            mem_wb_reg <= mem_wb_next;
        if (rst)
            mem_wb_reg.valid <= 1'b0;
        else
            mem_wb_reg.valid <= mem_wb_next.valid;  // one retire per strobe
    end

    always_comb
    begin
        retire.valid    = mem_wb_reg.valid;
        retire.rd_s     = mem_wb_reg.rd_s;
        retire.we       = mem_wb_reg.regf_we & (mem_wb_reg.rd_s != 5'd0);  // x0 stays zero
        retire.rd_wdata = mem_wb_reg.mem_read ? mem_wb_reg.read_data : mem_wb_reg.rd_v;
        retire.mon      = mem_wb_reg.mon;
    end

    // an x0 record retires next cycle without a register write
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        (mem_wb_next.valid && mem_wb_next.rd_s == 5'd0) |=> (retire.valid && !retire.we)
    ) else $error("wb_stage: register write to x0");

endmodule

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/100ps

module mem_subsystem (
    input  logic                     clk,
    input  logic                     rst,
    input  rv32i_types::ex_mem_reg_t ex_mem_in,
    output logic                     dstall,
    output rv32i_types::retire_t     retire
);
    import rv32i_types::*;

    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;
    mem_wb_reg_t mem_wb_next;

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .ex_mem_in   (ex_mem_in),
        .dmem_rdata  (dmem_rdata),
        .dmem_resp   (dmem_resp),
        .dmem_req    (dmem_req),
        .dstall      (dstall),
        .mem_wb_next (mem_wb_next)
    );

    data_mem u_data_mem (
        .clk        (clk),
        .rst        (rst),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp)
    );

    wb_stage u_wb_stage (
        .clk         (clk),
        .rst         (rst),
        .mem_wb_next (mem_wb_next),
        .retire      (retire)
    );

endmodule

// ==== tb/mem_subsystem_tb.sv ====
`timescale 1ns/100ps

module mem_subsystem_tb;
    import rv32i_types::*;

    localparam int INIT_OPS   = 64;     // one word store per word in use
    localparam int RAND_OPS   = 300;
    localparam int N_OPS      = INIT_OPS + RAND_OPS;
    localparam int RST_CYCLES = 16;
    localparam int PERIOD_NS  = 100;
    localparam int TIMEOUT_NS = (N_OPS * 6 + RST_CYCLES + 100) * PERIOD_NS;

    typedef struct packed {
        retire_t     rec;
        logic        chk_rdata;     // mem_rdata is undefined on a store
        logic [31:0] due;           // cycle count when the retire must show
    } exp_t;

    logic        clk = 1'b0;
    logic        rst;
    ex_mem_reg_t ex_mem_in;
    logic        dstall;
    retire_t     retire;

    integer      seed;
    int          errors;
    int          checked;
    logic [31:0] cyc = '0;
    logic [63:0] next_order;
    logic [63:0] next_retire;
    logic [7:0]  ref_mem [256];     // bytes of the first 64 words
    exp_t        exp_q [$];

    mem_subsystem dut (
        .clk       (clk),
        .rst       (rst),
        .ex_mem_in (ex_mem_in),
        .dstall    (dstall),
        .retire    (retire)
    );

    initial
    begin
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    // expected retire record for one operation, word is the memory word before the access
    function automatic retire_t expect_retire(input ex_mem_reg_t op, input logic [31:0] word);
        retire_t     rec;
        logic [1:0]  off;
        logic [7:0]  byte_v;
        logic [15:0] half_v;
        off    = op.alu_result[1:0];
        byte_v = 8'(word >> (8 * off));
        half_v = 16'(word >> (8 * off));
        rec = '0;
        rec.valid     = 1'b1;
        rec.rd_s      = op.rd_s;
        rec.we        = op.regf_we && (op.rd_s != 5'd0);
        rec.rd_wdata  = op.alu_result;
        rec.mon.order = op.mon.order;
        if (op.mem_read || op.mem_write)
            rec.mon.mem_addr = {op.alu_result[31:2], 2'b00};
        if (op.mem_read)
        begin
            rec.mon.mem_rdata = word;
            case (op.funct3)
                lb:
                begin
                    rec.mon.mem_rmask = 4'b0001 << off;
                    rec.rd_wdata      = {{24{byte_v[7]}}, byte_v};
                end
                lbu:
                begin
                    rec.mon.mem_rmask = 4'b0001 << off;
                    rec.rd_wdata      = {24'b0, byte_v};
                end
                lh:
                begin
                    rec.mon.mem_rmask = 4'b0011 << off;
                    rec.rd_wdata      = {{16{half_v[15]}}, half_v};
                end
                lhu:
                begin
                    rec.mon.mem_rmask = 4'b0011 << off;
                    rec.rd_wdata      = {16'b0, half_v};
                end
                default:
                begin
                    rec.mon.mem_rmask = 4'b1111;
                    rec.rd_wdata      = word;
                end
            endcase
        end
        if (op.mem_write)
        begin
            case (op.funct3)
                sb:
                begin
                    rec.mon.mem_wmask = 4'b0001 << off;
                    rec.mon.mem_wdata = {24'b0, op.rs2_v[7:0]} << (8 * off);
                end
                sh:
                begin
                    rec.mon.mem_wmask = 4'b0011 << off;
                    rec.mon.mem_wdata = {16'b0, op.rs2_v[15:0]} << (8 * off);
                end
                default:
                begin
                    rec.mon.mem_wmask = 4'b1111;
                    rec.mon.mem_wdata = op.rs2_v;
                end
            endcase
        end
        return rec;
    endfunction

    task automatic log_mismatch(input string name, input logic [63:0] expv,
                                input logic [63:0] gotv);
        $display("Error at %0t: %s expected %h got %h", $time, name, expv, gotv);
        errors++;
    endtask

    // random aligned store, load or non-memory op
    task automatic make_op(output ex_mem_reg_t op);
        int         kind;
        int         word_idx;
        int         pick;
        logic [1:0] off;
        op       = '0;
        kind     = $unsigned($random(seed)) % 3;
        word_idx = $unsigned($random(seed)) % 64;
        pick     = $unsigned($random(seed)) % 5;
        off      = 2'($random(seed));
        op.rs2_v   = $random(seed);
        op.rd_s    = 5'($random(seed));
        op.regf_we = 1'($random(seed));
        if ($unsigned($random(seed)) % 8 == 0)
            op.rd_s = 5'd0;             // x0 shows up often enough
        op.funct3 = lw;
        if (kind == 2)
        begin
            op.alu_result = $random(seed);
        end
        else
        begin
            if (kind == 0)
            begin
                op.mem_write = 1'b1;
                op.funct3 = (pick % 3 == 0) ? sb : (pick % 3 == 1) ? sh : sw;
            end
            else
            begin
                op.mem_read = 1'b1;
                case (pick)
                    0:       op.funct3 = lb;
                    1:       op.funct3 = lbu;
                    2:       op.funct3 = lh;
                    3:       op.funct3 = lhu;
                    default: op.funct3 = lw;
                endcase
            end
            case (op.funct3)
                lb, lbu: off = off;
                lh, lhu: off[0] = 1'b0;
                default: off = 2'b00;
            endcase
            op.alu_result = {24'b0, 6'(word_idx), off};
        end
    endtask

    // called on a falling edge, returns on the falling edge after the strobe
    task automatic issue_op(input ex_mem_reg_t op);
        exp_t        e;
        logic [31:0] word;
        logic [7:0]  base;
        logic        is_mem;
        while (dstall)
            @(negedge clk);
        base   = {op.alu_result[7:2], 2'b00};
        word   = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
        is_mem = op.mem_read | op.mem_write;
        op.valid     = 1'b1;
        op.mon       = '0;
        op.mon.order = next_order;
        next_order++;
        e.rec       = expect_retire(op, word);
        e.chk_rdata = !op.mem_write;
        e.due       = cyc + (is_mem ? 2 : 1);
        for (int i = 0; i < 4; i++)
        begin
            if (e.rec.mon.mem_wmask[i])
                ref_mem[base + i] = e.rec.mon.mem_wdata[8*i +: 8];
        end
        exp_q.push_back(e);
        ex_mem_in = op;
        @(negedge clk);
        ex_mem_in.valid = 1'b0;
        if (is_mem && dstall !== 1'b1)
            log_mismatch("dstall", 64'd1, {63'd0, dstall});
    endtask

    always @(negedge clk)
    begin : compare
        exp_t e;
        if (rst === 1'b0 && retire.valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Error at %0t: retire with no operation outstanding", $time);
                errors++;
            end
            else
            begin
                e = exp_q.pop_front();
                checked++;
                if (cyc !== e.due)
                    log_mismatch("retire cycle", e.due, cyc);
                if (retire.mon.order !== next_retire)
                    log_mismatch("retire.mon.order sequence", next_retire, retire.mon.order);
                next_retire = retire.mon.order + 1;
                if (retire.mon.order !== e.rec.mon.order)
                    log_mismatch("retire.mon.order", e.rec.mon.order, retire.mon.order);
                if (retire.rd_s !== e.rec.rd_s)
                    log_mismatch("retire.rd_s", e.rec.rd_s, retire.rd_s);
                if (retire.we !== e.rec.we)
                    log_mismatch("retire.we", e.rec.we, retire.we);
                if (retire.rd_wdata !== e.rec.rd_wdata)
                    log_mismatch("retire.rd_wdata", e.rec.rd_wdata, retire.rd_wdata);
                if (retire.mon.mem_addr !== e.rec.mon.mem_addr)
                    log_mismatch("retire.mon.mem_addr", e.rec.mon.mem_addr, retire.mon.mem_addr);
                if (retire.mon.mem_rmask !== e.rec.mon.mem_rmask)
                    log_mismatch("retire.mon.mem_rmask", e.rec.mon.mem_rmask,
                                 retire.mon.mem_rmask);
                if (retire.mon.mem_wmask !== e.rec.mon.mem_wmask)
                    log_mismatch("retire.mon.mem_wmask", e.rec.mon.mem_wmask,
                                 retire.mon.mem_wmask);
                if (retire.mon.mem_wdata !== e.rec.mon.mem_wdata)
                    log_mismatch("retire.mon.mem_wdata", e.rec.mon.mem_wdata,
                                 retire.mon.mem_wdata);
                if (e.chk_rdata && retire.mon.mem_rdata !== e.rec.mon.mem_rdata)
                    log_mismatch("retire.mon.mem_rdata", e.rec.mon.mem_rdata,
                                 retire.mon.mem_rdata);
            end
        end
    end

    initial
    begin
        ex_mem_reg_t op;
        int          idle;
        rst         = 1'b1;
        ex_mem_in   = '0;
        seed        = 32'hcd6cc009;
        errors      = 0;
        checked     = 0;
        next_order  = '0;
        next_retire = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // fill every word in use, back to back, so later loads see known data
        for (int w = 0; w < INIT_OPS; w++)
        begin
            op = '0;
            op.mem_write  = 1'b1;
            op.funct3     = sw;
            op.alu_result = w * 4;
            op.rs2_v      = ((w * 4) * 32'h01000193) ^ 32'h3c96a5f0;
            op.rd_s       = 5'(w);
            op.regf_we    = w[0];
            issue_op(op);
        end

        for (int n = 0; n < RAND_OPS; n++)
        begin
            make_op(op);
            issue_op(op);
            if ($unsigned($random(seed)) % 4 == 0)
            begin
                idle = 1 + $unsigned($random(seed)) % 3;
                repeat (idle) @(negedge clk);
            end
        end

        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);     // catch stray retires

        $display("%0d of %0d operations retired, %0d outstanding, %0d errors",
                 checked, N_OPS, exp_q.size(), errors);
        if (errors == 0 && checked == N_OPS)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: %0d retires were missing, %0d errors so far", exp_q.size(), errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/rv32i_types.sv
verilog/dmem_bank.sv
verilog/mem_stage.sv
verilog/data_mem.sv
verilog/wb_stage.sv
verilog/mem_subsystem.sv
tb/mem_subsystem_tb.sv
